// ==== Makefile ====
TOP := tb_mem_model
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST OK" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)

// ==== common/mem_model_pkg.sv ====
package mem_model_pkg;

`include "mem_model_settings.svh"

   // byte address and store index
   typedef logic [`ADDR_WIDTH-1:0]      addr_t;
   typedef logic [`WORD_ADDR_WIDTH-1:0] word_addr_t;

   // payload
   typedef logic [`WORD_BYTES*8-1:0]    data_t;
   typedef logic [`WORD_BYTES-1:0]      mask_t;   // one enable per byte
   typedef logic [`LEN_WIDTH-1:0]       len_t;

   // throttle
   typedef logic [`SHARE_WIDTH-1:0]     share_t;
   typedef logic [`BUCKET_WIDTH-1:0]    bucket_t;

   // which requester is tested first this cycle
   typedef enum logic {
      PHASE_RD_FIRST = 1'b0,
      PHASE_WR_FIRST = 1'b1
   } phase_e;

endpackage

// ==== common/mem_model_settings.svh ====
`ifndef MEM_MODEL_SETTINGS_SVH
`define MEM_MODEL_SETTINGS_SVH

// byte address on the command ports
`define ADDR_WIDTH 32

// one data word is one store word
`define WORD_BYTES 8

// word store
`define MEM_DEPTH 256
`define WORD_ADDR_WIDTH 8

// burst length counts beats minus one
`define LEN_WIDTH 4

// bandwidth throttle
`define SHARE_WIDTH 8
`define BUCKET_WIDTH 16
`define SCALE_FACTOR 4   // cost of one beat
`define MAX_PORTS 2      // drain multiplier

// request queues
`define QUEUE_DEPTH 4
`define QUEUE_PTR_WIDTH 2

`endif

// ==== flist.f ====
+incdir+common
common/mem_model_pkg.sv
queue/write_req_queue.sv
queue/read_req_queue.sv
source/bandwidth_throttle.sv
source/mem_array.sv
source/mem_model_top.sv
tb/tb_mem_model.sv

// ==== queue/read_req_queue.sv ====
`include "mem_model_settings.svh"

module read_req_queue import mem_model_pkg::*; #(
   parameter addr_t mem_addr_start = '0
) (
   input  logic       clk,
   input  logic       reset,
   input  logic       cmd_rd,
   input  addr_t      rd_addr,
   input  len_t       rd_len,
   output logic       rd_ready,
   output logic       head_vld,
   output word_addr_t head_index,
   output len_t       head_len,
   input  logic       grant
);

   localparam int OFFSET_BITS = $clog2(`WORD_BYTES);
   localparam logic [`QUEUE_PTR_WIDTH:0] FULL_COUNT = `QUEUE_DEPTH;

   word_addr_t q_index [`QUEUE_DEPTH];
   len_t       q_len   [`QUEUE_DEPTH];

   logic [`QUEUE_PTR_WIDTH-1:0] wr_ptr;
   logic [`QUEUE_PTR_WIDTH-1:0] rd_ptr;
   logic [`QUEUE_PTR_WIDTH:0]   count;
   addr_t                       offset;
   logic                        push;
   logic                        pop;

   assign offset   = rd_addr - mem_addr_start;
   assign rd_ready = (count != FULL_COUNT);
   assign push     = cmd_rd && rd_ready;
   assign pop      = grant;   // store latches the data on the same edge

   assign head_vld   = (count != '0);
   assign head_index = q_index[rd_ptr];
   assign head_len   = q_len[rd_ptr];

   // payload slots
   always_ff @(posedge clk) begin
      if (push) begin
         q_index[wr_ptr] <= offset[OFFSET_BITS +: `WORD_ADDR_WIDTH];
         q_len[wr_ptr]   <= rd_len;
      end
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // throttle must only grant a queued read
   a_no_pop_empty: assert property (@(posedge clk) disable iff (!reset)
      pop |-> (count != '0))
      else $error("read queue popped while empty");

endmodule

// ==== queue/write_req_queue.sv ====
`include "mem_model_settings.svh"

module write_req_queue import mem_model_pkg::*; #(
   parameter addr_t mem_addr_start = '0
) (
   input  logic       clk,
   input  logic       reset,
   input  logic       cmd_wr,
   input  addr_t      wr_addr,
   input  data_t      wr_data,
   input  mask_t      wr_mask,
   input  len_t       wr_len,
   output logic       wr_ready,
   output logic       head_vld,
   output word_addr_t head_index,
   output data_t      head_data,
   output mask_t      head_mask,
   output len_t       head_len,
   input  logic       grant,
   output logic       wrresp_vld
);

   localparam int OFFSET_BITS = $clog2(`WORD_BYTES);
   localparam logic [`QUEUE_PTR_WIDTH:0] FULL_COUNT = `QUEUE_DEPTH;

   word_addr_t q_index [`QUEUE_DEPTH];
   data_t      q_data  [`QUEUE_DEPTH];
   mask_t      q_mask  [`QUEUE_DEPTH];
   len_t       q_len   [`QUEUE_DEPTH];

   logic [`QUEUE_PTR_WIDTH-1:0] wr_ptr;
   logic [`QUEUE_PTR_WIDTH-1:0] rd_ptr;
   logic [`QUEUE_PTR_WIDTH:0]   count;
   addr_t                       offset;
   logic                        push;
   logic                        pop;

   assign offset   = wr_addr - mem_addr_start;   // byte offset into the store
   assign wr_ready = (count != FULL_COUNT);
   assign push     = cmd_wr && wr_ready;
   assign pop      = grant;

   // head of the queue
   assign head_vld   = (count != '0);
   assign head_index = q_index[rd_ptr];
   assign head_data  = q_data[rd_ptr];
   assign head_mask  = q_mask[rd_ptr];
   assign head_len   = q_len[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         q_index[wr_ptr] <= offset[OFFSET_BITS +: `WORD_ADDR_WIDTH];
         q_data[wr_ptr]  <= wr_data;
         q_mask[wr_ptr]  <= wr_mask;
         q_len[wr_ptr]   <= wr_len;
      end
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         wrresp_vld <= 1'b0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         wrresp_vld <= pop;   // ack one cycle after the store write
      end
   end

   // an accepted write never lands on the occupied head slot
   a_no_push_full: assert property (@(posedge clk) disable iff (!reset)
      push |-> !(head_vld && wr_ptr == rd_ptr))
      else $error("write queue accepted a command while full");

endmodule

// ==== source/bandwidth_throttle.sv ====
`include "mem_model_settings.svh"

module bandwidth_throttle import mem_model_pkg::*; (
   input  logic   clk,
   input  logic   reset,
   input  share_t bw_share,
   input  logic   wr_head_vld,
   input  len_t   wr_len,
   input  logic   rd_head_vld,
   input  len_t   rd_len,
   output logic   wr_grant,
   output logic   rd_grant
);

   // one spare bit to see a wrap of the bucket
   localparam int LEVEL_WIDTH = `BUCKET_WIDTH + 1;
   typedef logic [LEVEL_WIDTH-1:0] level_t;

   bucket_t bucket_q;
   phase_e  phase_q;
   level_t  drain;
   level_t  level;
   logic    first_vld;
   logic    second_vld;
   level_t  first_cost;
   level_t  second_cost;
   logic    first_grant;
   logic    second_grant;

   function automatic level_t charge(len_t len);
      return level_t'((int'(len) + 1) * `SCALE_FACTOR);
   endfunction

   assign drain = level_t'(`MAX_PORTS * bw_share);

   // requester with priority goes first
   assign first_vld   = (phase_q == PHASE_RD_FIRST) ? rd_head_vld : wr_head_vld;
   assign second_vld  = (phase_q == PHASE_RD_FIRST) ? wr_head_vld : rd_head_vld;
   assign first_cost  = (phase_q == PHASE_RD_FIRST) ? charge(rd_len) : charge(wr_len);
   assign second_cost = (phase_q == PHASE_RD_FIRST) ? charge(wr_len) : charge(rd_len);

   always_comb begin
      // drain, floored at zero
      if (level_t'(bucket_q) < drain) level = '0;
      else level = level_t'(bucket_q) - drain;

      first_grant = first_vld && (level < drain);
      if (first_grant) level = level + first_cost;

      second_grant = second_vld && (level < drain);   // sees the updated level
      if (second_grant) level = level + second_cost;
   end

   assign rd_grant = (phase_q == PHASE_RD_FIRST) ? first_grant : second_grant;
   assign wr_grant = (phase_q == PHASE_RD_FIRST) ? second_grant : first_grant;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         bucket_q <= '0;
         phase_q  <= PHASE_RD_FIRST;
      end else begin
         bucket_q <= level[`BUCKET_WIDTH-1:0];
         phase_q  <= (phase_q == PHASE_RD_FIRST) ? PHASE_WR_FIRST : PHASE_RD_FIRST;
      end
   end

   // grants only for a valid head in the queues
   a_grant_vld: assert property (@(posedge clk) disable iff (!reset)
      (wr_grant |-> wr_head_vld) and (rd_grant |-> rd_head_vld))
      else $error("grant given without a valid queue head");

   // spare bit is set by a wrap in either direction
   a_no_overflow: assert property (@(posedge clk) disable iff (!reset)
      !level[`BUCKET_WIDTH])
      else $error("bucket level wrapped outside its width");

endmodule

// ==== source/mem_array.sv ====
`include "mem_model_settings.svh"

module mem_array import mem_model_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       wr_en,
   input  word_addr_t wr_index,
   input  data_t      wr_data,
   input  mask_t      wr_mask,
   input  logic       rd_en,
   input  word_addr_t rd_index,
   output data_t      rd_data,
   output logic       rd_vld
);

   data_t mem [`MEM_DEPTH];

   // byte-masked write
   always_ff @(posedge clk) begin
      for (int i = 0; i < `WORD_BYTES; i++) begin
         if (wr_en && wr_mask[i]) begin
            mem[wr_index][i*8 +: 8] <= wr_data[i*8 +: 8];
         end
      end
   end

   // read register, old word on a same-index write
   always_ff @(posedge clk) begin
      if (rd_en) rd_data <= mem[rd_index];
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         rd_vld <= 1'b0;
      end else begin
         rd_vld <= rd_en;   // one pulse per read grant
      end
   end

endmodule

// ==== source/mem_model_top.sv ====
module mem_model_top import mem_model_pkg::*; #(
   parameter addr_t mem_addr_start = '0
) (
   input  logic   clk,
   input  logic   reset,
   input  share_t bw_share,
   input  logic   cmd_wr,
   input  addr_t  wr_addr,
   input  data_t  wr_data,
   input  mask_t  wr_mask,
   input  len_t   wr_len,
   output logic   wr_ready,
   input  logic   cmd_rd,
   input  addr_t  rd_addr,
   input  len_t   rd_len,
   output logic   rd_ready,
   output logic   wrresp_vld,
   output logic   rdresp_vld,
   output data_t  rdresp_data
);

   // write queue head
   logic       wr_head_vld;
   word_addr_t wr_head_index;
   data_t      wr_head_data;
   mask_t      wr_head_mask;
   len_t       wr_head_len;
   logic       wr_grant;

   // read queue head
   logic       rd_head_vld;
   word_addr_t rd_head_index;
   len_t       rd_head_len;
   logic       rd_grant;

   write_req_queue #(.mem_addr_start(mem_addr_start)) i_write_req_queue (
      .clk        (clk),
      .reset      (reset),
      .cmd_wr     (cmd_wr),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data),
      .wr_mask    (wr_mask),
      .wr_len     (wr_len),
      .wr_ready   (wr_ready),
      .head_vld   (wr_head_vld),
      .head_index (wr_head_index),
      .head_data  (wr_head_data),
      .head_mask  (wr_head_mask),
      .head_len   (wr_head_len),
      .grant      (wr_grant),
      .wrresp_vld (wrresp_vld)
   );

   read_req_queue #(.mem_addr_start(mem_addr_start)) i_read_req_queue (
      .clk        (clk),
      .reset      (reset),
      .cmd_rd     (cmd_rd),
      .rd_addr    (rd_addr),
      .rd_len     (rd_len),
      .rd_ready   (rd_ready),
      .head_vld   (rd_head_vld),
      .head_index (rd_head_index),
      .head_len   (rd_head_len),
      .grant      (rd_grant)
   );

   bandwidth_throttle i_bandwidth_throttle (
      .clk         (clk),
      .reset       (reset),
      .bw_share    (bw_share),
      .wr_head_vld (wr_head_vld),
      .wr_len      (wr_head_len),
      .rd_head_vld (rd_head_vld),
      .rd_len      (rd_head_len),
      .wr_grant    (wr_grant),
      .rd_grant    (rd_grant)
   );

   // store output is the read response
   mem_array i_mem_array (
      .clk      (clk),
      .reset    (reset),
      .wr_en    (wr_grant),
      .wr_index (wr_head_index),
      .wr_data  (wr_head_data),
      .wr_mask  (wr_head_mask),
      .rd_en    (rd_grant),
      .rd_index (rd_head_index),
      .rd_data  (rdresp_data),
      .rd_vld   (rdresp_vld)
   );

endmodule

// ==== tb/tb_mem_model.sv ====
`include "mem_model_settings.svh"

module tb_mem_model import mem_model_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam addr_t MEM_START   = '0;   // default base of the DUT
   localparam int    CYCLE_LIMIT = 4000;
   localparam int    GAP_LIMIT   = 20;
   localparam int    SLACK       = 2 * 64;   // two maximum charges
   localparam len_t  RATE_LEN    = 15;
   localparam int    RATE_CHARGE = (RATE_LEN + 1) * `SCALE_FACTOR;

   logic   clk;
   logic   reset;
   share_t bw_share;
   logic   cmd_wr;
   addr_t  wr_addr;
   data_t  wr_data;
   mask_t  wr_mask;
   len_t   wr_len;
   logic   wr_ready;
   logic   cmd_rd;
   addr_t  rd_addr;
   len_t   rd_len;
   logic   rd_ready;
   logic   wrresp_vld;
   logic   rdresp_vld;
   data_t  rdresp_data;

   integer seed;
   int     error_count;
   int     cycle_count;
   int     tests_passed;
   int     tests_failed;
   int     wr_acc_total;
   int     rd_acc_total;
   int     wr_rsp_total;
   int     rd_rsp_total;
   int     start_errors;
   int     start_wr_acc;
   int     start_rd_acc;
   int     start_wr_rsp;
   int     start_rd_rsp;
   logic   feeding;
   logic   rate_check;
   int     level_f;     // charged minus drained since the window start
   int     level_min;
   int     gap;
   logic   seen_resp;

   data_t      ref_mem [`MEM_DEPTH];
   word_addr_t wr_idx_q[$];   // accepted writes waiting for wrresp_vld
   data_t      wr_data_q[$];
   mask_t      wr_mask_q[$];
   data_t      exp_q[$];      // expected read data in command order

   mem_model_top i_mem_model_top (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) cycle_count++;

   initial begin
      wait (cycle_count >= CYCLE_LIMIT);
      $display("run stopped after %0d cycles with tests still running", cycle_count);
      $display("TEST FAILED");
      $finish;
   end

   function automatic addr_t make_addr(input word_addr_t idx);
      addr_t wrap;
      addr_t off;
      wrap = addr_t'($unsigned($random(seed)) % 16);   // aliases above the store
      off  = addr_t'($unsigned($random(seed)) % `WORD_BYTES);
      return MEM_START + (wrap * `MEM_DEPTH + addr_t'(idx)) * `WORD_BYTES + off;
   endfunction

   function automatic word_addr_t to_index(input addr_t addr);
      return word_addr_t'((addr - MEM_START) / `WORD_BYTES);
   endfunction

   function automatic word_addr_t pick_index(input int base, input int span);
      return word_addr_t'(base + int'($unsigned($random(seed)) % span));
   endfunction

   function automatic data_t merge(input data_t old, input data_t new_data, input mask_t mask);
      data_t res;
      res = old;
      for (int i = 0; i < `WORD_BYTES; i++) begin
         if (mask[i]) res[i*8 +: 8] = new_data[i*8 +: 8];
      end
      return res;
   endfunction

   task automatic offer_write(input word_addr_t idx, input mask_t mask, input len_t len);
      cmd_wr  = 1'b1;
      wr_addr = make_addr(idx);
      wr_data = data_t'({$random(seed), $random(seed)});
      wr_mask = mask;
      wr_len  = len;
   endtask

   task automatic offer_read(input word_addr_t idx, input len_t len);
      cmd_rd  = 1'b1;
      rd_addr = make_addr(idx);
      rd_len  = len;
   endtask

   // ready seen at a falling edge means acceptance on the next rising edge
   task automatic send_write(input word_addr_t idx, input mask_t mask, input len_t len);
      @(negedge clk);
      offer_write(idx, mask, len);
      while (!wr_ready) @(negedge clk);
   endtask

   task automatic send_read(input word_addr_t idx, input len_t len);
      @(negedge clk);
      offer_read(idx, len);
      while (!rd_ready) @(negedge clk);
   endtask

   task automatic stop_write();
      @(negedge clk);
      cmd_wr = 1'b0;
   endtask

   task automatic stop_read();
      @(negedge clk);
      cmd_rd = 1'b0;
   endtask

   task automatic wait_idle();
      int waited;
      waited = 0;
      while ((wr_idx_q.size() != 0 || exp_q.size() != 0) && waited < 400) begin
         @(negedge clk);
         waited++;
      end
      assert (wr_idx_q.size() == 0 && exp_q.size() == 0) else begin
         error_count++;
         $display("commands still outstanding at %0t after %0d cycles", $time, waited);
      end
   endtask

   task automatic begin_test();
      start_errors = error_count;
      start_wr_acc = wr_acc_total;
      start_rd_acc = rd_acc_total;
      start_wr_rsp = wr_rsp_total;
      start_rd_rsp = rd_rsp_total;
   endtask

   task automatic finish_test(input string name);
      int wr_acc;
      int rd_acc;
      wr_acc = wr_acc_total - start_wr_acc;
      rd_acc = rd_acc_total - start_rd_acc;
      assert (wr_acc == wr_rsp_total - start_wr_rsp && rd_acc == rd_rsp_total - start_rd_rsp)
      else begin
         error_count++;
         $display("Mismatch at %0t: %s response count differs from the accepted commands",
                  $time, name);
      end
      if (error_count == start_errors) begin
         tests_passed++;
         $display("test %s: passed, %0d writes and %0d reads", name, wr_acc, rd_acc);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, error_count - start_errors);
      end
   endtask

   // reference model and scoreboard, sampled on the edge that moves the DUT
   always @(posedge clk) begin : monitor
      word_addr_t idx;
      data_t      exp;
      if (reset) begin
         if (wrresp_vld) begin
            wr_rsp_total++;
            assert (wr_idx_q.size() != 0) else begin
               error_count++;
               $display("write response at %0t with no write outstanding", $time);
            end
            if (wr_idx_q.size() != 0) begin
               idx = wr_idx_q.pop_front();
               ref_mem[idx] = merge(ref_mem[idx], wr_data_q.pop_front(), wr_mask_q.pop_front());
            end
         end
         if (rdresp_vld) begin
            rd_rsp_total++;
            assert (exp_q.size() != 0) else begin
               error_count++;
               $display("read response at %0t with no read outstanding", $time);
            end
            if (exp_q.size() != 0) begin
               exp = exp_q.pop_front();
               assert (rdresp_data === exp) else begin
                  error_count++;
                  $display("Mismatch at %0t: read data %h, expected %h", $time, rdresp_data, exp);
               end
            end
         end
         if (cmd_wr && wr_ready) begin
            wr_idx_q.push_back(to_index(wr_addr));
            wr_data_q.push_back(wr_data);
            wr_mask_q.push_back(wr_mask);
            wr_acc_total++;
         end
         if (cmd_rd && rd_ready) begin
            exp_q.push_back(ref_mem[to_index(rd_addr)]);
            rd_acc_total++;
         end
      end
      if (!rate_check) begin
         level_f   = 0;
         level_min = 0;
         gap       = 0;
         seen_resp = 1'b0;
      end else begin
         // worst window is the highest level above the lowest earlier level
         level_f += (int'(wrresp_vld) + int'(rdresp_vld)) * RATE_CHARGE
                    - `MAX_PORTS * int'(bw_share);
         assert (level_f - level_min <= SLACK) else begin
            error_count++;
            $display("responses at %0t exceed the bandwidth share by %0d",
                     $time, level_f - level_min - SLACK);
         end
         if (level_f < level_min) level_min = level_f;
         if (wrresp_vld || rdresp_vld) begin
            seen_resp = 1'b1;
            gap = 0;
         end else if (seen_resp) begin
            gap++;
         end
         assert (gap <= GAP_LIMIT) else begin
            error_count++;
            $display("no response for %0d cycles at %0t with both queues full", gap, $time);
            gap = 0;
         end
      end
   end

   // zero share for two edges means no grant and so no pulse
   a_no_resp_zero_share: assert property (@(posedge clk) disable iff (!reset)
      (bw_share == '0 && $past(bw_share) == '0) |-> (!wrresp_vld && !rdresp_vld))
      else begin
         error_count++;
         $display("response at %0t while the bandwidth share was zero", $time);
      end

   a_rd_data_known: assert property (@(posedge clk) disable iff (!reset)
      rdresp_vld |-> !$isunknown(rdresp_data))
      else begin
         error_count++;
         $display("read data at %0t has unknown bits", $time);
      end

   initial begin
      seed       = 25923;
      reset      = 1'b0;
      bw_share   = '0;
      cmd_wr     = 1'b0;
      wr_addr    = '0;
      wr_data    = '0;
      wr_mask    = '0;
      wr_len     = '0;
      cmd_rd     = 1'b0;
      rd_addr    = '0;
      rd_len     = '0;
      feeding    = 1'b0;
      rate_check = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b1;

      begin_test();
      @(negedge clk);
      assert (!wrresp_vld && !rdresp_vld && wr_ready && rd_ready) else begin
         error_count++;
         $display("outputs not idle after reset at %0t", $time);
      end
      finish_test("reset state");

      // full words first so that every byte is known, then masked merges
      begin_test();
      bw_share = 8'd64;
      for (int i = 0; i < 16; i++) send_write(word_addr_t'(i), '1, len_t'($random(seed)));
      for (int i = 0; i < 16; i++) begin
         send_write(pick_index(0, 16), mask_t'($random(seed)), len_t'($random(seed)));
      end
      stop_write();
      wait_idle();
      for (int i = 0; i < 16; i++) send_read(word_addr_t'(i), len_t'($random(seed)));
      for (int i = 0; i < 8; i++) send_read(pick_index(0, 16), len_t'($random(seed)));
      stop_read();
      wait_idle();
      finish_test("masked writes and reads");

      begin_test();
      bw_share = '0;
      for (int i = 0; i < `QUEUE_DEPTH; i++) send_write(word_addr_t'(128 + i), '1, '0);
      @(negedge clk);
      offer_write(word_addr_t'(128 + `QUEUE_DEPTH), '1, '0);   // held while full
      for (int i = 0; i < `QUEUE_DEPTH; i++) send_read(pick_index(0, 16), '0);
      @(negedge clk);
      offer_read(pick_index(0, 16), '0);
      repeat (20) begin
         @(negedge clk);
         assert (!wr_ready && !rd_ready) else begin
            error_count++;
            $display("ready rose at %0t with full queues and a zero share", $time);
         end
      end
      bw_share = 8'd64;
      fork
         begin
            while (!wr_ready) @(negedge clk);
            stop_write();
         end
         begin
            while (!rd_ready) @(negedge clk);
            stop_read();
         end
      join
      wait_idle();
      assert (wr_acc_total - start_wr_acc == `QUEUE_DEPTH + 1 &&
              rd_acc_total - start_rd_acc == `QUEUE_DEPTH + 1) else begin
         error_count++;
         $display("Mismatch at %0t: held commands were not all accepted", $time);
      end
      finish_test("zero share hold");

      // reads stay clear of the written words, so expectations hold
      begin_test();
      bw_share   = 8'd3;
      rate_check = 1'b1;
      feeding    = 1'b1;
      fork
         begin
            while (feeding) send_write(pick_index(128, 64), '1, RATE_LEN);
            stop_write();
         end
         begin
            while (feeding) send_read(pick_index(0, 16), RATE_LEN);
            stop_read();
         end
         begin
            repeat (1500) @(posedge clk);
            feeding = 1'b0;
            @(negedge clk);
            rate_check = 1'b0;
         end
      join
      wait_idle();
      finish_test("bandwidth limit");

      $display("tests passed: %0d, tests failed: %0d, errors: %0d",
               tests_passed, tests_failed, error_count);
      if (tests_failed == 0 && error_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule
